/* sources.f */
design/video_cfg_pkg.sv
design/host_link.sv
design/cmd_decoder.sv
design/aspect_select.sv
design/muldiv_seq.sv
design/window_fsm.sv
design/video_cfg_top.sv
testbench/tb_video_cfg.sv

/* testbench/tb_video_cfg.sv */
// Video configuration testbench
module tb_video_cfg
	import video_cfg_pkg::*;
();

	// Roughly four times the combined test length
	localparam int CYCLE_LIMIT = 40000;
	localparam int SETTLE      = 200;

	logic   clk_sys;
	logic   resetd;
	logic   i_sel;
	logic   i_req;
	word_t  i_data;
	ratio_t i_core_arx;
	ratio_t i_core_ary;
	logic   o_ack;
	dim_t   o_h_total, o_v_total;
	dim_t   o_hmin, o_hmax, o_vmin, o_vmax;

	integer seed;
	int     cycles;
	int     pass_cnt;
	int     fail_cnt;
	word_t  frame_buf [0:15];

	// Reference register file
	dim_t   m_width, m_hfp, m_hs, m_hbp;
	dim_t   m_height, m_vfp, m_vs, m_vbp;
	dim_t   m_hset, m_vset;
	logic   m_free;
	ratio_t m_arc [0:3];
	ratio_t cur_arx, cur_ary;
	dim_t   exp_hmin, exp_hmax, exp_vmin, exp_vmax;

	video_cfg_top #(
		.OP_W (12)
	) video_cfg_top_inst (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sel      (i_sel),
		.i_req      (i_req),
		.i_data     (i_data),
		.i_core_arx (i_core_arx),
		.i_core_ary (i_core_ary),
		.o_ack      (o_ack),
		.o_h_total  (o_h_total),
		.o_v_total  (o_v_total),
		.o_hmin     (o_hmin),
		.o_hmax     (o_hmax),
		.o_vmin     (o_vmin),
		.o_vmax     (o_vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	// Drive point just after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic check_value(input string name, input dim_t got, input dim_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic end_test(input string name, input int fails_before);
		if (fail_cnt == fails_before)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, fail_cnt - fails_before);
	endtask

	// Quotient of a 24 bit product clipped at 4095
	function automatic dim_t scale(input dim_t a, input dim_t b, input dim_t d);
		int q;
		q = (int'(a) * int'(b)) / int'(d);
		return (q > 4095) ? 12'd4095 : dim_t'(q);
	endfunction

	task automatic model_window();
		ratio_t sx, sy;
		dim_t   ax, ay, ow, oh, w, h;
		logic   dir;
		if (cur_ary != '0) begin
			sx = cur_arx;
			sy = cur_ary;
		end else if (cur_arx == 13'd1) begin
			sx = m_arc[0];
			sy = m_arc[1];
		end else if (cur_arx == 13'd2) begin
			sx = m_arc[2];
			sy = m_arc[3];
		end else begin
			sx = '0;
			sy = '0;
		end
		ax  = sx[11:0];
		ay  = sy[11:0];
		dir = sx[12] | sy[12];
		ow  = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
		oh  = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
		if (m_free || ax == 0 || ay == 0) begin
			w = ow;
			h = oh;
		end else if (dir) begin
			w = ax;
			h = ay;
		end else begin
			w = scale(oh, ax, ay);
			h = scale(ow, ay, ax);
		end
		if (w > ow)
			w = ow;
		if (h > oh)
			h = oh;
		exp_hmin = (m_width - w) >> 1;
		exp_hmax = exp_hmin + w - 12'd1;
		exp_vmin = (m_height - h) >> 1;
		exp_vmax = exp_vmin + h - 12'd1;
	endtask

	task automatic check_outputs();
		model_window();
		check_value("o_h_total", o_h_total, m_width + m_hfp + m_hs + m_hbp);
		check_value("o_v_total", o_v_total, m_height + m_vfp + m_vs + m_vbp);
		check_value("o_hmin", o_hmin, exp_hmin);
		check_value("o_hmax", o_hmax, exp_hmax);
		check_value("o_vmin", o_vmin, exp_vmin);
		check_value("o_vmax", o_vmax, exp_vmax);
	endtask

	// Register file update for one frame in frame_buf
	task automatic apply_frame(input int n);
		cmd_t cmd;
		int   i;
		int   k;
		cmd = frame_buf[0][7:0];
		for (i = 1; i < n; i++) begin
			k = i - 1;
			case (cmd)
				CMD_TIMING: begin
					case (k)
						0: m_width  = frame_buf[i][11:0];
						1: m_hfp    = frame_buf[i][11:0];
						2: m_hs     = frame_buf[i][11:0];
						3: m_hbp    = frame_buf[i][11:0];
						4: m_height = frame_buf[i][11:0];
						5: m_vfp    = frame_buf[i][11:0];
						6: m_vs     = frame_buf[i][11:0];
						7: m_vbp    = frame_buf[i][11:0];
						default: ;
					endcase
				end
				CMD_VSET: if (k == 0) m_vset = frame_buf[i][11:0];
				CMD_HSET: begin
					if (k == 0) begin
						m_hset = frame_buf[i][11:0];
						m_free = frame_buf[i][15];
					end
				end
				CMD_CUSTOM_AR: if (k < 4) m_arc[k] = frame_buf[i][12:0];
				default: ;
			endcase
		end
	endtask

	////////////////////////////////////////
	// Host link driver
	////////////////////////////////////////
	task automatic host_word(input word_t w);
		int gap;
		int waited;
		gap = $random(seed) & 3;
		repeat (gap) step();
		if (o_ack !== 1'b0) begin
			$display("Acknowledge was high before request rose at %0t", $time);
			fail_cnt++;
		end
		i_data = w;
		i_req  = 1'b1;
		waited = 0;
		while (o_ack !== 1'b1 && waited < 20) begin
			step();
			waited++;
		end
		if (o_ack !== 1'b1) begin
			$display("Stalled acknowledge at %0t, no rise within 20 cycles", $time);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
		i_req  = 1'b0;
		waited = 0;
		while (o_ack !== 1'b0 && waited < 20) begin
			step();
			waited++;
		end
		if (o_ack !== 1'b0) begin
			$display("Stalled acknowledge at %0t, no fall within 20 cycles", $time);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic send_frame(input int n);
		int i;
		i_sel = 1'b1;
		step();
		for (i = 0; i < n; i++)
			host_word(frame_buf[i]);
		step();
		i_sel = 1'b0;
		repeat (3) step();
		apply_frame(n);
	endtask

	// Random upper bits around a payload
	function automatic word_t pad_word(input int v, input int keep);
		word_t w;
		w = $random(seed);
		if (keep == 12)
			w[11:0] = v[11:0];
		else
			w[12:0] = v[12:0];
		return w;
	endfunction

	task automatic set_core(input ratio_t x, input ratio_t y);
		i_core_arx = x;
		i_core_ary = y;
		cur_arx    = x;
		cur_ary    = y;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		int i;
		int j;
		int mark;
		int n;
		word_t w;
		seed     = 32'hfb03;
		cycles   = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		resetd   = 1'b1;
		i_sel    = 1'b0;
		i_req    = 1'b0;
		i_data   = '0;
		set_core('0, '0);
		m_width  = 12'd1920;
		m_hfp    = 12'd88;
		m_hs     = 12'd48;
		m_hbp    = 12'd148;
		m_height = 12'd1080;
		m_vfp    = 12'd4;
		m_vs     = 12'd5;
		m_vbp    = 12'd36;
		m_hset   = '0;
		m_vset   = '0;
		m_free   = 1'b0;
		for (i = 0; i < 4; i++)
			m_arc[i] = '0;

		// 1. Reset state
		mark = fail_cnt;
		repeat (10) begin
			step();
			check_value("o_ack", dim_t'(o_ack), 12'd0);
		end
		resetd = 1'b0;
		step();
		check_value("o_ack", dim_t'(o_ack), 12'd0);
		repeat (SETTLE) step();
		check_outputs();
		end_test("reset", mark);

		// 2. Handshake with select low
		mark = fail_cnt;
		for (i = 0; i < 50; i++)
			host_word($random(seed));
		end_test("handshake", mark);

		// 3. Timing frames with trailing words
		mark = fail_cnt;
		for (i = 0; i < 6; i++) begin
			n = 9 + rand_range(1, 3);
			frame_buf[0] = {8'h00, CMD_TIMING};
			for (j = 1; j < n; j++)
				frame_buf[j] = pad_word(rand_range(1, 2047), 12);
			send_frame(n);
			repeat (SETTLE) step();
			check_outputs();
		end
		end_test("timing", mark);

		// 4. Core ratio with size limits and free scale
		mark = fail_cnt;
		for (i = 0; i < 12; i++) begin
			w = pad_word(rand_range(0, 2400), 12);
			w[15] = (i % 4 == 3);
			frame_buf[0] = {8'h00, CMD_HSET};
			frame_buf[1] = w;
			send_frame(2);
			frame_buf[0] = {8'h00, CMD_VSET};
			frame_buf[1] = pad_word(rand_range(0, 2400), 12);
			send_frame(2);
			// Small y terms push the quotient past 4095
			if (i % 3 == 0)
				set_core(13'(rand_range(1, 4095)), 13'(rand_range(1, 7)));
			else
				set_core(13'(rand_range(1, 4095)), 13'(rand_range(1, 4095)));
			repeat (SETTLE) step();
			check_outputs();
		end
		end_test("core_ratio", mark);

		// 5. Custom ratios picked by index
		mark = fail_cnt;
		frame_buf[0] = {8'h00, CMD_HSET};
		frame_buf[1] = {4'h0, 12'(rand_range(0, 2400))};
		send_frame(2);
		for (i = 0; i < 6; i++) begin
			frame_buf[0] = {8'h00, CMD_CUSTOM_AR};
			for (j = 1; j < 5; j++) begin
				n = rand_range(0, 4095);
				if (rand_range(0, 3) == 0)
					n = n | 4096;
				frame_buf[j] = pad_word(n, 13);
			end
			send_frame(5);
			for (j = 0; j < 3; j++) begin
				if (j == 2)
					set_core(13'(rand_range(3, 8191)), '0);
				else
					set_core(13'(j + 1), '0);
				repeat (SETTLE) step();
				check_outputs();
			end
		end
		end_test("custom_ratio", mark);

		// 6. Aborted timing frame and a fresh VSET frame
		mark = fail_cnt;
		set_core('0, '0);
		frame_buf[0] = {8'h00, CMD_TIMING};
		for (j = 1; j < 4; j++)
			frame_buf[j] = pad_word(rand_range(1, 2047), 12);
		send_frame(4);
		frame_buf[0] = {8'h00, CMD_VSET};
		frame_buf[1] = pad_word(rand_range(1, int'(m_height) - 1), 12);
		send_frame(2);
		repeat (SETTLE) step();
		check_outputs();
		end_test("frame_abort", mark);

		$display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* design/video_cfg_top.sv */
// Video configuration top level
module video_cfg_top
	import video_cfg_pkg::*;
#(
	parameter int OP_W = 12
) (
	input  logic   clk_sys,
	input  logic   resetd,
	input  logic   i_sel,
	input  logic   i_req,
	input  word_t  i_data,
	input  ratio_t i_core_arx,
	input  ratio_t i_core_ary,
	output logic   o_ack,
	output dim_t   o_h_total,
	output dim_t   o_v_total,
	output dim_t   o_hmin,
	output dim_t   o_hmax,
	output dim_t   o_vmin,
	output dim_t   o_vmax
);

	logic   sel, strobe;
	word_t  word;
	dim_t   width, height, hset, vset;
	logic   freescale;
	ratio_t arc1x, arc1y, arc2x, arc2y;
	dim_t   arx, ary, out_width, out_height;
	logic   direct;
	logic   md_start, md_busy;
	dim_t   md_mul1, md_mul2, md_div, md_result;

	////////////////////////////////////////
	// Host side
	////////////////////////////////////////
	host_link host_link_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_sel    (i_sel),
		.i_req    (i_req),
		.i_data   (i_data),
		.o_ack    (o_ack),
		.o_sel    (sel),
		.o_strobe (strobe),
		.o_word   (word)
	);

	cmd_decoder cmd_decoder_inst (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_sel       (sel),
		.i_strobe    (strobe),
		.i_word      (word),
		.o_width     (width),
		.o_height    (height),
		.o_hset      (hset),
		.o_vset      (vset),
		.o_freescale (freescale),
		.o_arc1x     (arc1x),
		.o_arc1y     (arc1y),
		.o_arc2x     (arc2x),
		.o_arc2y     (arc2y),
		.o_h_total   (o_h_total),
		.o_v_total   (o_v_total)
	);

	////////////////////////////////////////
	// Window calculation
	////////////////////////////////////////
	aspect_select aspect_select_inst (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_core_arx   (i_core_arx),
		.i_core_ary   (i_core_ary),
		.i_arc1x      (arc1x),
		.i_arc1y      (arc1y),
		.i_arc2x      (arc2x),
		.i_arc2y      (arc2y),
		.i_width      (width),
		.i_height     (height),
		.i_hset       (hset),
		.i_vset       (vset),
		.o_arx        (arx),
		.o_ary        (ary),
		.o_direct     (direct),
		.o_out_width  (out_width),
		.o_out_height (out_height)
	);

	window_fsm window_fsm_inst (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_width      (width),
		.i_height     (height),
		.i_out_width  (out_width),
		.i_out_height (out_height),
		.i_arx        (arx),
		.i_ary        (ary),
		.i_direct     (direct),
		.i_freescale  (freescale),
		.i_md_busy    (md_busy),
		.i_md_result  (md_result),
		.o_md_start   (md_start),
		.o_md_mul1    (md_mul1),
		.o_md_mul2    (md_mul2),
		.o_md_div     (md_div),
		.o_hmin       (o_hmin),
		.o_hmax       (o_hmax),
		.o_vmin       (o_vmin),
		.o_vmax       (o_vmax)
	);

	muldiv_seq #(
		.OP_W (OP_W)
	) muldiv_seq_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

endmodule

/* design/window_fsm.sv */
// Display window state machine
module window_fsm
	import video_cfg_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  dim_t i_width,
	input  dim_t i_height,
	input  dim_t i_out_width,
	input  dim_t i_out_height,
	input  dim_t i_arx,
	input  dim_t i_ary,
	input  logic i_direct,
	input  logic i_freescale,
	input  logic i_md_busy,
	input  dim_t i_md_result,
	output logic o_md_start,
	output dim_t o_md_mul1,
	output dim_t o_md_mul2,
	output dim_t o_md_div,
	output dim_t o_hmin,
	output dim_t o_hmax,
	output dim_t o_vmin,
	output dim_t o_vmax
);

	typedef enum logic [2:0] {
		S_DECIDE, S_WREQ, S_WWAIT, S_HREQ, S_HWAIT, S_LIMIT, S_PLACE
	} state_t;

	state_t state;
	dim_t   wcalc, hcalc;
	dim_t   videow, videoh;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state      <= S_DECIDE;
			o_md_start <= 1'b0;
			o_hmin     <= '0;
			o_hmax     <= '0;
			o_vmin     <= '0;
			o_vmax     <= '0;
		end else begin
			o_md_start <= 1'b0;
			case (state)
				S_DECIDE: begin
					if (i_freescale || i_arx == '0 || i_ary == '0) begin
						wcalc <= i_out_width;
						hcalc <= i_out_height;
						state <= S_LIMIT;
					end else if (i_direct) begin
						// Ratio terms are the size itself
						wcalc <= i_arx;
						hcalc <= i_ary;
						state <= S_LIMIT;
					end else begin
						state <= S_WREQ;
					end
				end
				// Width from height * x / y
				S_WREQ: begin
					o_md_mul1  <= i_out_height;
					o_md_mul2  <= i_arx;
					o_md_div   <= i_ary;
					o_md_start <= 1'b1;
					state      <= S_WWAIT;
				end
				S_WWAIT: begin
					if (!o_md_start && !i_md_busy) begin
						wcalc <= i_md_result;
						state <= S_HREQ;
					end
				end
				// Height from width * y / x
				S_HREQ: begin
					o_md_mul1  <= i_out_width;
					o_md_mul2  <= i_ary;
					o_md_div   <= i_arx;
					o_md_start <= 1'b1;
					state      <= S_HWAIT;
				end
				S_HWAIT: begin
					if (!o_md_start && !i_md_busy) begin
						hcalc <= i_md_result;
						state <= S_LIMIT;
					end
				end
				S_LIMIT: begin
					videow <= (wcalc > i_out_width) ? i_out_width : wcalc;
					videoh <= (hcalc > i_out_height) ? i_out_height : hcalc;
					state  <= S_PLACE;
				end
				// Centre within the programmed frame
				S_PLACE: begin
					o_hmin <= (i_width - videow) >> 1;
					o_hmax <= ((i_width - videow) >> 1) + videow - 1'd1;
					o_vmin <= (i_height - videoh) >> 1;
					o_vmax <= ((i_height - videoh) >> 1) + videoh - 1'd1;
					state  <= S_DECIDE;
				end
				default: state <= S_DECIDE;
			endcase
		end
	end

endmodule

/* design/muldiv_seq.sv */
// Sequential multiply then divide
module muldiv_seq #(
	parameter int OP_W = 12
) (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic            i_start,
	input  logic [OP_W-1:0] i_mul1,
	input  logic [OP_W-1:0] i_mul2,
	input  logic [OP_W-1:0] i_div,
	output logic            o_busy,
	output logic [OP_W-1:0] o_result
);

	localparam int PROD_W = 2 * OP_W;
	localparam int CNT_W  = $clog2(PROD_W + 1);

	logic [PROD_W-1:0] quo;
	logic [OP_W:0]     rem;
	logic [OP_W-1:0]   div_r;
	logic [CNT_W-1:0]  cnt;
	logic [OP_W:0]     rem_shift;
	logic              q_bit;

	// Restoring step on the next dividend bit
	assign rem_shift = {rem[OP_W-1:0], quo[PROD_W-1]};
	assign q_bit     = (rem_shift >= {1'b0, div_r});

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			cnt    <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			cnt    <= CNT_W'(PROD_W);
		end else if (o_busy) begin
			cnt <= cnt - 1'd1;
			if (cnt == 1)
				o_busy <= 1'b0;
		end
	end

	// Product seeds the quotient shift register
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo   <= i_mul1 * i_mul2;
			rem   <= '0;
			div_r <= i_div;
		end else if (o_busy) begin
			rem <= q_bit ? rem_shift - {1'b0, div_r} : rem_shift;
			quo <= {quo[PROD_W-2:0], q_bit};
		end
	end

	// Saturate when the quotient overflows OP_W bits
	assign o_result = (|quo[PROD_W-1:OP_W]) ? '1 : quo[OP_W-1:0];

endmodule

/* design/aspect_select.sv */
// Aspect ratio source and output size
module aspect_select
	import video_cfg_pkg::*;
(
	input  logic   clk_sys,
	input  logic   resetd,
	input  ratio_t i_core_arx,
	input  ratio_t i_core_ary,
	input  ratio_t i_arc1x,
	input  ratio_t i_arc1y,
	input  ratio_t i_arc2x,
	input  ratio_t i_arc2y,
	input  dim_t   i_width,
	input  dim_t   i_height,
	input  dim_t   i_hset,
	input  dim_t   i_vset,
	output dim_t   o_arx,
	output dim_t   o_ary,
	output logic   o_direct,
	output dim_t   o_out_width,
	output dim_t   o_out_height
);

	ratio_t sel_x, sel_y;

	// Zero y from the core picks a custom ratio by index in x
	always_comb begin
		if (i_core_ary != '0) begin
			sel_x = i_core_arx;
			sel_y = i_core_ary;
		end else if (i_core_arx == 13'd1) begin
			sel_x = i_arc1x;
			sel_y = i_arc1y;
		end else if (i_core_arx == 13'd2) begin
			sel_x = i_arc2x;
			sel_y = i_arc2y;
		end else begin
			sel_x = '0;
			sel_y = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_arx        <= '0;
			o_ary        <= '0;
			o_direct     <= 1'b0;
			o_out_width  <= '0;
			o_out_height <= '0;
		end else begin
			o_arx        <= sel_x[11:0];
			o_ary        <= sel_y[11:0];
			o_direct     <= sel_x[12] | sel_y[12];
			// Limit only applies when set and smaller
			o_out_width  <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
			o_out_height <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
		end
	end

endmodule

/* design/cmd_decoder.sv */
// Host command decoder
module cmd_decoder
	import video_cfg_pkg::*;
(
	input  logic   clk_sys,
	input  logic   resetd,
	input  logic   i_sel,
	input  logic   i_strobe,
	input  word_t  i_word,
	output dim_t   o_width,
	output dim_t   o_height,
	output dim_t   o_hset,
	output dim_t   o_vset,
	output logic   o_freescale,
	output ratio_t o_arc1x,
	output ratio_t o_arc1y,
	output ratio_t o_arc2x,
	output ratio_t o_arc2y,
	output dim_t   o_h_total,
	output dim_t   o_v_total
);

	logic       has_cmd;
	cmd_t       cmd;
	logic [3:0] cnt;
	dim_t       hfp, hs, hbp;
	dim_t       vfp, vs, vbp;

	////////////////////////////////////////
	// Frame tracking and register file
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cmd         <= '0;
			cnt         <= '0;
			o_width     <= DEF_WIDTH;
			hfp         <= DEF_HFP;
			hs          <= DEF_HS;
			hbp         <= DEF_HBP;
			o_height    <= DEF_HEIGHT;
			vfp         <= DEF_VFP;
			vs          <= DEF_VS;
			vbp         <= DEF_VBP;
			o_hset      <= '0;
			o_vset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (!i_sel) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			cnt     <= '0;
		end else if (i_strobe) begin
			if (!has_cmd) begin
				// First word of the frame is the command
				has_cmd <= 1'b1;
				cmd     <= i_word[7:0];
				cnt     <= '0;
			end else begin
				// Counter sticks at the top, trailing words fall through
				if (cnt != 4'hf)
					cnt <= cnt + 1'd1;
				case (cmd)
					CMD_TIMING: begin
						if (cnt < TIMING_WORDS) begin
							case (cnt[2:0])
								3'd0: o_width  <= i_word[11:0];
								3'd1: hfp      <= i_word[11:0];
								3'd2: hs       <= i_word[11:0];
								3'd3: hbp      <= i_word[11:0];
								3'd4: o_height <= i_word[11:0];
								3'd5: vfp      <= i_word[11:0];
								3'd6: vs       <= i_word[11:0];
								3'd7: vbp      <= i_word[11:0];
							endcase
						end
					end
					CMD_VSET: begin
						if (cnt == 0)
							o_vset <= i_word[11:0];
					end
					CMD_HSET: begin
						if (cnt == 0) begin
							o_hset      <= i_word[11:0];
							o_freescale <= i_word[15];
						end
					end
					CMD_CUSTOM_AR: begin
						case (cnt)
							4'd0: o_arc1x <= i_word[12:0];
							4'd1: o_arc1y <= i_word[12:0];
							4'd2: o_arc2x <= i_word[12:0];
							4'd3: o_arc2y <= i_word[12:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// Line and frame totals
	always_ff @(posedge clk_sys) begin
		o_h_total <= o_width + hfp + hs + hbp;
		o_v_total <= o_height + vfp + vs + vbp;
	end

endmodule

/* design/host_link.sv */
// Host req/ack link
module host_link
	import video_cfg_pkg::*;
(
	input  logic  clk_sys,
	input  logic  resetd,
	input  logic  i_sel,
	input  logic  i_req,
	input  word_t i_data,
	output logic  o_ack,
	output logic  o_sel,
	output logic  o_strobe,
	output word_t o_word
);

	logic  req_s1, req_s2;
	logic  sel_s1, sel_s2;
	logic  ack_q;
	word_t data_s1, data_s2;

	// Two stages into clk_sys, then the acknowledge stage
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
			sel_s1 <= 1'b0;
			sel_s2 <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			req_s1 <= i_req;
			req_s2 <= req_s1;
			sel_s1 <= i_sel;
			sel_s2 <= sel_s1;
			ack_q  <= req_s2;
		end
	end

	// Word travels alongside req, stable while req is high
	always_ff @(posedge clk_sys) begin
		data_s1 <= i_data;
		data_s2 <= data_s1;
	end

	// One strobe per rising req
	assign o_strobe = req_s2 & ~ack_q;
	assign o_word   = data_s2;
	assign o_sel    = sel_s2;
	assign o_ack    = ack_q;

endmodule

/* design/video_cfg_pkg.sv */
// Video configuration definitions
package video_cfg_pkg;

	// Host word and dimension widths
	localparam int WORD_W = 16;
	localparam int DIM_W  = 12;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [DIM_W-1:0]  dim_t;
	// Top bit is the direct-size flag
	typedef logic [DIM_W:0]    ratio_t;
	typedef logic [7:0]        cmd_t;

	// Host command codes
	localparam cmd_t CMD_TIMING    = 8'h20;
	localparam cmd_t CMD_VSET      = 8'h27;
	localparam cmd_t CMD_HSET      = 8'h37;
	localparam cmd_t CMD_CUSTOM_AR = 8'h3A;

	// 1920x1080 timing after reset
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HFP    = 12'd88;
	localparam dim_t DEF_HS     = 12'd48;
	localparam dim_t DEF_HBP    = 12'd148;
	localparam dim_t DEF_HEIGHT = 12'd1080;
	localparam dim_t DEF_VFP    = 12'd4;
	localparam dim_t DEF_VS     = 12'd5;
	localparam dim_t DEF_VBP    = 12'd36;

	localparam int TIMING_WORDS = 8;

endpackage
